// ==== src/xbar_pkg.sv ====
package xbar_pkg;

  // message and port geometry
  localparam int msg_width = 32;
  localparam int n_inputs = 2;
  localparam int n_outputs = 2;
  localparam int in_sel_width = $clog2(n_inputs);
  localparam int out_sel_width = $clog2(n_outputs);

  // route word, input select in the high bits, output select in the low bits
  localparam int ctrl_width = $clog2(n_inputs * n_outputs);

  // spi frame, opcode on top of the payload
  localparam int opcode_width = 4;
  localparam int frame_width = opcode_width + msg_width;
  // room to count past a full frame so long frames are caught
  localparam int bit_cnt_width = $clog2(frame_width + 2);
  localparam int sync_stages = 2;

  // response queue
  localparam int queue_depth = 4;
  localparam int queue_ptr_width = $clog2(queue_depth);
  localparam int queue_cnt_width = $clog2(queue_depth + 1);

  typedef enum logic [opcode_width-1:0] {
    op_nop   = 4'h0,
    op_route = 4'h1,
    op_msg   = 4'h2,
    op_read  = 4'h3,
    // device to host
    op_data  = 4'h8,
    op_empty = 4'h9
  } spi_opcode_e;

endpackage

// ==== src/spi_minion.sv ====
`timescale 1ns/100ps

module spi_minion (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             cs_n,
  input  logic                             sclk,
  input  logic                             mosi,
  output logic                             miso,
  input  logic [xbar_pkg::frame_width-1:0] tx_frame,
  output logic [xbar_pkg::frame_width-1:0] rx_frame,
  output logic                             rx_val
);

  logic [xbar_pkg::sync_stages-1:0] cs_sync;
  logic [xbar_pkg::sync_stages-1:0] sclk_sync;
  logic [xbar_pkg::sync_stages-1:0] mosi_sync;
  logic                             cs_s;
  logic                             sclk_s;
  logic                             mosi_s;
  logic                             cs_q;
  logic                             sclk_q;
  logic                             cs_fall;
  logic                             cs_rise;
  logic                             sclk_rise;
  logic                             sclk_fall;
  logic [xbar_pkg::bit_cnt_width-1:0] bit_cnt;
  logic [xbar_pkg::frame_width-1:0]   rx_shift;
  logic [xbar_pkg::frame_width-1:0]   tx_shift;

  // pins into the clk domain, idle levels while in reset
  always_ff @(posedge clk) begin
    if (reset) begin
      cs_sync   <= '1;
      sclk_sync <= '0;
      mosi_sync <= '0;
      cs_q      <= 1'b1;
      sclk_q    <= 1'b0;
    end else begin
      cs_sync   <= {cs_sync[xbar_pkg::sync_stages-2:0], cs_n};
      sclk_sync <= {sclk_sync[xbar_pkg::sync_stages-2:0], sclk};
      mosi_sync <= {mosi_sync[xbar_pkg::sync_stages-2:0], mosi};
      cs_q      <= cs_s;
      sclk_q    <= sclk_s;
    end
  end

  assign cs_s   = cs_sync[xbar_pkg::sync_stages-1];
  assign sclk_s = sclk_sync[xbar_pkg::sync_stages-1];
  assign mosi_s = mosi_sync[xbar_pkg::sync_stages-1];

  assign cs_fall   = !cs_s && cs_q;
  assign cs_rise   = cs_s && !cs_q;
  // sclk edges only count inside a frame
  assign sclk_rise = sclk_s && !sclk_q && !cs_s;
  assign sclk_fall = !sclk_s && sclk_q && !cs_s;

  // bit counter saturates so overlong frames never alias to a full one
  always_ff @(posedge clk) begin
    if (reset) begin
      bit_cnt <= '0;
    end else if (cs_fall) begin
      bit_cnt <= '0;
    end else if (sclk_rise && bit_cnt != '1) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // mode 0, sample mosi on rising sclk, msb first
  always_ff @(posedge clk) begin
    if (sclk_rise) begin
      rx_shift <= {rx_shift[xbar_pkg::frame_width-2:0], mosi_s};
    end
  end

  // response loaded at frame start, next bit presented after each falling sclk
  always_ff @(posedge clk) begin
    if (reset) begin
      tx_shift <= '0;
    end else if (cs_fall) begin
      tx_shift <= tx_frame;
    end else if (sclk_fall) begin
      tx_shift <= {tx_shift[xbar_pkg::frame_width-2:0], 1'b0};
    end
  end

  assign miso = tx_shift[xbar_pkg::frame_width-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      rx_val <= 1'b0;
    end else begin
      rx_val <= cs_rise && (bit_cnt == xbar_pkg::bit_cnt_width'(xbar_pkg::frame_width));
    end
  end

  assign rx_frame = rx_shift;

  // one report per frame
  a_rx_val_pulse: assert property (@(posedge clk) disable iff (reset) rx_val |=> !rx_val);

endmodule

// ==== src/spi_packet_decoder.sv ====
`timescale 1ns/100ps

module spi_packet_decoder (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [xbar_pkg::frame_width-1:0] rx_frame,
  input  logic                             rx_val,
  output logic [xbar_pkg::frame_width-1:0] tx_frame,
  output logic [xbar_pkg::ctrl_width-1:0]  control,
  output logic                             control_val,
  output logic [xbar_pkg::msg_width-1:0]   msg,
  output logic                             msg_val,
  input  logic                             msg_rdy,
  output logic                             pop,
  input  logic [xbar_pkg::msg_width-1:0]   pop_msg,
  input  logic                             pop_valid
);

  xbar_pkg::spi_opcode_e            rx_op;
  logic [xbar_pkg::msg_width-1:0]   rx_payload;
  logic                             route_req;
  logic                             msg_req;
  logic                             read_req;
  logic                             msg_load;

  assign rx_op = xbar_pkg::spi_opcode_e'(
    rx_frame[xbar_pkg::frame_width-1 -: xbar_pkg::opcode_width]);
  assign rx_payload = rx_frame[xbar_pkg::msg_width-1:0];

  always_comb begin
    route_req = 1'b0;
    msg_req   = 1'b0;
    read_req  = 1'b0;
    if (rx_val) begin
      case (rx_op)
        xbar_pkg::op_route: route_req = 1'b1;
        xbar_pkg::op_msg:   msg_req = 1'b1;
        xbar_pkg::op_read:  read_req = 1'b1;
        // nop and device side codes do nothing
        default: ;
      endcase
    end
  end

  // route write, one cycle pulse after the frame
  always_ff @(posedge clk) begin
    if (reset) begin
      control_val <= 1'b0;
    end else begin
      control_val <= route_req;
    end
  end

  always_ff @(posedge clk) begin
    if (route_req) begin
      control <= rx_payload[xbar_pkg::ctrl_width-1:0];
    end
  end

  // single message slot, a new op_msg is dropped while it is occupied
  assign msg_load = msg_req && !msg_val;

  always_ff @(posedge clk) begin
    if (reset) begin
      msg_val <= 1'b0;
    end else if (msg_val && msg_rdy) begin
      msg_val <= 1'b0;
    end else if (msg_load) begin
      msg_val <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (msg_load) begin
      msg <= rx_payload;
    end
  end

  // pop one cycle after the read frame, capture the head in the same edge
  always_ff @(posedge clk) begin
    if (reset) begin
      pop      <= 1'b0;
      tx_frame <= '0;
    end else begin
      pop <= read_req;
      if (pop) begin
        tx_frame <= pop_valid ? {xbar_pkg::op_data, pop_msg}
                              : {xbar_pkg::op_empty, {xbar_pkg::msg_width{1'b0}}};
      end
    end
  end

endmodule

// ==== src/crossbar_blocking.sv ====
`timescale 1ns/100ps

module crossbar_blocking (
  input  logic                            clk,
  input  logic                            reset,

  input  logic [xbar_pkg::msg_width-1:0]  recv_msg [xbar_pkg::n_inputs],
  input  logic                            recv_val [xbar_pkg::n_inputs],
  output logic                            recv_rdy [xbar_pkg::n_inputs],

  output logic [xbar_pkg::msg_width-1:0]  send_msg [xbar_pkg::n_outputs],
  output logic                            send_val [xbar_pkg::n_outputs],
  input  logic                            send_rdy [xbar_pkg::n_outputs],

  input  logic [xbar_pkg::ctrl_width-1:0] control,
  input  logic                            control_val,
  output logic                            control_rdy,

  // force the spi side of the selection
  input  logic                            input_spi,
  input  logic                            output_spi
);

  logic [xbar_pkg::ctrl_width-1:0]    stored_control;
  logic [xbar_pkg::in_sel_width-1:0]  input_sel;
  logic [xbar_pkg::out_sel_width-1:0] output_sel;
  logic [xbar_pkg::n_outputs-1:0]     send_val_vec;

  always_ff @(posedge clk) begin
    if (reset) begin
      stored_control <= '0;
    end else if (control_val) begin
      stored_control <= control;
    end
  end

  // route updates are always accepted
  assign control_rdy = 1'b1;

  always_comb begin
    input_sel  = stored_control[xbar_pkg::ctrl_width-1 -: xbar_pkg::in_sel_width];
    output_sel = stored_control[xbar_pkg::out_sel_width-1:0];
    if (input_spi) begin
      input_sel = '0;
    end
    if (output_spi) begin
      output_sel = '0;
    end
  end

  // one path through, everything else idle
  always_comb begin
    for (int i = 0; i < xbar_pkg::n_outputs; i++) begin
      if (i == int'(output_sel)) begin
        send_msg[i] = recv_msg[input_sel];
        send_val[i] = recv_val[input_sel];
      end else begin
        send_msg[i] = '0;
        send_val[i] = 1'b0;
      end
    end
    for (int i = 0; i < xbar_pkg::n_inputs; i++) begin
      if (i == int'(input_sel)) begin
        recv_rdy[i] = send_rdy[output_sel];
      end else begin
        recv_rdy[i] = 1'b0;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < xbar_pkg::n_outputs; i++) begin
      send_val_vec[i] = send_val[i];
    end
  end

  a_one_send_val: assert property (@(posedge clk) disable iff (reset) $onehot0(send_val_vec));

  for (genvar g = 0; g < xbar_pkg::n_inputs; g++) begin : g_rdy_chk
    // ready never leaks to an unselected source
    a_rdy_sel: assert property (@(posedge clk) disable iff (reset)
      recv_rdy[g] |-> int'(input_sel) == g);
  end

endmodule

// ==== src/spi_response_queue.sv ====
`timescale 1ns/100ps

module spi_response_queue (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [xbar_pkg::msg_width-1:0] push_msg,
  input  logic                           push_val,
  output logic                           push_rdy,
  input  logic                           pop,
  output logic [xbar_pkg::msg_width-1:0] pop_msg,
  output logic                           pop_valid
);

  logic [xbar_pkg::msg_width-1:0]       mem [xbar_pkg::queue_depth];
  logic [xbar_pkg::queue_ptr_width-1:0] wr_ptr;
  logic [xbar_pkg::queue_ptr_width-1:0] rd_ptr;
  logic [xbar_pkg::queue_cnt_width-1:0] count;
  logic                                 push_fire;
  logic                                 pop_fire;

  function automatic logic [xbar_pkg::queue_ptr_width-1:0] next_ptr(
    input logic [xbar_pkg::queue_ptr_width-1:0] ptr
  );
    if (ptr == xbar_pkg::queue_ptr_width'(xbar_pkg::queue_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push_rdy  = count != xbar_pkg::queue_cnt_width'(xbar_pkg::queue_depth);
  assign pop_valid = count != '0;
  assign pop_msg   = mem[rd_ptr];

  assign push_fire = push_val && push_rdy;
  // pop on empty is ignored
  assign pop_fire  = pop && pop_valid;

  always_ff @(posedge clk) begin
    if (push_fire) begin
      mem[wr_ptr] <= push_msg;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop_fire) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push_fire, pop_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // an accepted push always finds a free slot
  a_push_not_full: assert property (@(posedge clk) disable iff (reset)
    push_fire |-> count < xbar_pkg::queue_cnt_width'(xbar_pkg::queue_depth));

endmodule

// ==== src/spi_xbar_top.sv ====
`timescale 1ns/100ps

module spi_xbar_top (
  input  logic                           clk,
  input  logic                           reset,
  // spi control port
  input  logic                           cs_n,
  input  logic                           sclk,
  input  logic                           mosi,
  output logic                           miso,
  // stream into crossbar input 1
  input  logic [xbar_pkg::msg_width-1:0] in_msg,
  input  logic                           in_val,
  output logic                           in_rdy,
  // stream from crossbar output 1
  output logic [xbar_pkg::msg_width-1:0] out_msg,
  output logic                           out_val,
  input  logic                           out_rdy,
  input  logic                           input_spi,
  input  logic                           output_spi
);

  logic [xbar_pkg::frame_width-1:0] rx_frame;
  logic                             rx_val;
  logic [xbar_pkg::frame_width-1:0] tx_frame;
  logic [xbar_pkg::ctrl_width-1:0]  control;
  logic                             control_val;
  logic                             pop;
  logic [xbar_pkg::msg_width-1:0]   pop_msg;
  logic                             pop_valid;

  logic [xbar_pkg::msg_width-1:0]   recv_msg [xbar_pkg::n_inputs];
  logic                             recv_val [xbar_pkg::n_inputs];
  logic                             recv_rdy [xbar_pkg::n_inputs];
  logic [xbar_pkg::msg_width-1:0]   send_msg [xbar_pkg::n_outputs];
  logic                             send_val [xbar_pkg::n_outputs];
  logic                             send_rdy [xbar_pkg::n_outputs];

  // port 1 on both sides is the external stream
  assign recv_msg[1]  = in_msg;
  assign recv_val[1]  = in_val;
  assign in_rdy       = recv_rdy[1];
  assign out_msg      = send_msg[1];
  assign out_val      = send_val[1];
  assign send_rdy[1]  = out_rdy;

  spi_minion spi_minion_i (
    .clk      (clk),
    .reset    (reset),
    .cs_n     (cs_n),
    .sclk     (sclk),
    .mosi     (mosi),
    .miso     (miso),
    .tx_frame (tx_frame),
    .rx_frame (rx_frame),
    .rx_val   (rx_val)
  );

  spi_packet_decoder spi_packet_decoder_i (
    .clk         (clk),
    .reset       (reset),
    .rx_frame    (rx_frame),
    .rx_val      (rx_val),
    .tx_frame    (tx_frame),
    .control     (control),
    .control_val (control_val),
    .msg         (recv_msg[0]),
    .msg_val     (recv_val[0]),
    .msg_rdy     (recv_rdy[0]),
    .pop         (pop),
    .pop_msg     (pop_msg),
    .pop_valid   (pop_valid)
  );

  crossbar_blocking crossbar_blocking_i (
    .clk         (clk),
    .reset       (reset),
    .recv_msg    (recv_msg),
    .recv_val    (recv_val),
    .recv_rdy    (recv_rdy),
    .send_msg    (send_msg),
    .send_val    (send_val),
    .send_rdy    (send_rdy),
    .control     (control),
    .control_val (control_val),
    .control_rdy (),
    .input_spi   (input_spi),
    .output_spi  (output_spi)
  );

  spi_response_queue spi_response_queue_i (
    .clk       (clk),
    .reset     (reset),
    .push_msg  (send_msg[0]),
    .push_val  (send_val[0]),
    .push_rdy  (send_rdy[0]),
    .pop       (pop),
    .pop_msg   (pop_msg),
    .pop_valid (pop_valid)
  );

endmodule

// ==== tb/tb_spi_xbar.sv ====
`timescale 1ns/100ps

module tb_spi_xbar;

  localparam int half_period = 4;
  localparam int frame_gap = 12;
  localparam int accept_limit = 20;
  // 6 tests of about 12 frames, 36 bits at 64 ns each, plus margin
  localparam int watchdog_ns = 6 * 12 * 36 * 64 + 50000;

  logic                           clk;
  logic                           reset;
  logic                           cs_n;
  logic                           sclk;
  logic                           mosi;
  logic                           miso;
  logic [xbar_pkg::msg_width-1:0] in_msg;
  logic                           in_val;
  logic                           in_rdy;
  logic [xbar_pkg::msg_width-1:0] out_msg;
  logic                           out_val;
  logic                           out_rdy;
  logic                           input_spi;
  logic                           output_spi;

  logic                           route_3_active;
  integer                         seed;
  logic [xbar_pkg::msg_width-1:0] expected [$];
  int check_errs = 0;
  int forced_out_errs = 0;
  int route3_rdy_errs = 0;
  int route3_data_errs = 0;
  int err_mark = 0;
  int tests_run = 0;
  int tests_failed = 0;

  spi_xbar_top spi_xbar_top_i (
    .clk        (clk),
    .reset      (reset),
    .cs_n       (cs_n),
    .sclk       (sclk),
    .mosi       (mosi),
    .miso       (miso),
    .in_msg     (in_msg),
    .in_val     (in_val),
    .in_rdy     (in_rdy),
    .out_msg    (out_msg),
    .out_val    (out_val),
    .out_rdy    (out_rdy),
    .input_spi  (input_spi),
    .output_spi (output_spi)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // port rules of the external stream
  a_no_out_forced: assert property (@(posedge clk) disable iff (reset)
    output_spi |-> !out_val)
    else begin
      forced_out_errs++;
      $display("ERROR at %0t ns: out_val high while output_spi is set", $time);
    end

  a_route3_rdy: assert property (@(posedge clk) disable iff (reset)
    route_3_active && !input_spi && !output_spi |-> in_rdy == out_rdy)
    else begin
      route3_rdy_errs++;
      $display("ERROR at %0t ns: in_rdy differs from out_rdy on route 3", $time);
    end

  a_route3_data: assert property (@(posedge clk) disable iff (reset)
    route_3_active && !input_spi && !output_spi |-> out_val == in_val && out_msg == in_msg)
    else begin
      route3_data_errs++;
      $display("ERROR at %0t ns: out_msg/out_val do not follow the input on route 3", $time);
    end

  function automatic int total_errors();
    return check_errs + forced_out_errs + route3_rdy_errs + route3_data_errs;
  endfunction

  function automatic logic [xbar_pkg::frame_width-1:0] make_frame(
    input xbar_pkg::spi_opcode_e        op,
    input logic [xbar_pkg::msg_width-1:0] payload
  );
    return {op, payload};
  endfunction

  // ends 1 ns after a rising edge
  task automatic tick(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    assert (got === exp) else begin
      check_errs++;
      $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input logic [xbar_pkg::msg_width-1:0] got,
                            input logic [xbar_pkg::msg_width-1:0] exp, input string what);
    assert (got === exp) else begin
      check_errs++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_frame(input logic [xbar_pkg::frame_width-1:0] got,
                             input logic [xbar_pkg::frame_width-1:0] exp, input string what);
    assert (got === exp) else begin
      check_errs++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // mode 0 host, mosi changes with falling sclk, miso taken at rising sclk
  task automatic spi_xfer(input logic [xbar_pkg::frame_width-1:0] tx, input int nbits,
                          output logic [xbar_pkg::frame_width-1:0] rx);
    logic [xbar_pkg::frame_width-1:0] shift;
    int i;
    shift = tx;
    rx = '0;
    cs_n = 1'b0;
    tick(half_period);
    for (i = 0; i < nbits; i++) begin
      mosi = shift[xbar_pkg::frame_width-1];
      shift = shift << 1;
      tick(half_period);
      sclk = 1'b1;
      rx = {rx[xbar_pkg::frame_width-2:0], miso};
      tick(half_period);
      sclk = 1'b0;
    end
    tick(half_period);
    cs_n = 1'b1;
    mosi = 1'b0;
    tick(frame_gap);
  endtask

  task automatic set_route(input logic [xbar_pkg::ctrl_width-1:0] r);
    logic [xbar_pkg::frame_width-1:0] rsp;
    route_3_active = 1'b0;
    spi_xfer(make_frame(xbar_pkg::op_route,
      {{(xbar_pkg::msg_width - xbar_pkg::ctrl_width){1'b0}}, r}), xbar_pkg::frame_width, rsp);
    route_3_active = (r == 2'd3);
  endtask

  task automatic inject(input logic [xbar_pkg::msg_width-1:0] data);
    logic [xbar_pkg::frame_width-1:0] rsp;
    spi_xfer(make_frame(xbar_pkg::op_msg, data), xbar_pkg::frame_width, rsp);
    expected.push_back(data);
  endtask

  // n reads back to back, each answer arrives in the following frame
  task automatic read_burst(input int n);
    logic [xbar_pkg::frame_width-1:0] rsp;
    logic [xbar_pkg::frame_width-1:0] exp;
    int i;
    spi_xfer(make_frame(xbar_pkg::op_read, '0), xbar_pkg::frame_width, rsp);
    for (i = 0; i < n; i++) begin
      if (i < n - 1) begin
        spi_xfer(make_frame(xbar_pkg::op_read, '0), xbar_pkg::frame_width, rsp);
      end else begin
        spi_xfer(make_frame(xbar_pkg::op_nop, '0), xbar_pkg::frame_width, rsp);
      end
      if (expected.size() > 0) begin
        exp = make_frame(xbar_pkg::op_data, expected.pop_front());
      end else begin
        exp = make_frame(xbar_pkg::op_empty, '0);
      end
      check_frame(rsp, exp, "read response");
    end
  endtask

  // entered at a falling edge with in_val up, returns just after the accepting edge
  task automatic wait_in_accept();
    int n;
    n = 0;
    while (!in_rdy && n < accept_limit) begin
      @(negedge clk);
      n++;
    end
    assert (in_rdy) else begin
      check_errs++;
      $display("stream message on in_msg was not accepted within %0d cycles", accept_limit);
    end
    tick(1);
  endtask

  task automatic finish_test(input string name);
    int n;
    n = total_errors() - err_mark;
    tests_run++;
    if (n == 0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, n);
    end
    err_mark = total_errors();
  endtask

  initial begin
    #(watchdog_ns);
    $display("watchdog expired before the tests finished");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    logic [xbar_pkg::msg_width-1:0]   data;
    logic [xbar_pkg::frame_width-1:0] rsp;
    int i;
    reset = 1'b1;
    cs_n = 1'b1;
    sclk = 1'b0;
    mosi = 1'b0;
    in_msg = '0;
    in_val = 1'b0;
    out_rdy = 1'b0;
    input_spi = 1'b0;
    output_spi = 1'b0;
    route_3_active = 1'b0;
    seed = 32'haee3;
    tick(8);
    reset = 1'b0;
    tick(2);

    // route 0 selects input 0, so stream traffic is neither taken nor passed on
    out_rdy = 1'b1;
    in_val = 1'b1;
    @(negedge clk);
    check_bit(out_val, 1'b0, "out_val after reset");
    check_bit(in_rdy, 1'b0, "in_rdy after reset");
    tick(1);
    in_val = 1'b0;
    read_burst(1);
    finish_test("after reset");

    set_route(2'd3);
    for (i = 0; i < 8; i++) begin
      data = $random(seed);
      in_msg = data;
      in_val = 1'b1;
      @(negedge clk);
      check_bit(out_val, 1'b1, "out_val on route 3");
      check_word(out_msg, data, "out_msg on route 3");
      check_bit(in_rdy, 1'b1, "in_rdy on route 3");
      tick(1);
    end
    // back-pressure holds the message in place
    data = $random(seed);
    in_msg = data;
    out_rdy = 1'b0;
    for (i = 0; i < 3; i++) begin
      @(negedge clk);
      check_bit(in_rdy, 1'b0, "in_rdy with out_rdy low");
      check_word(out_msg, data, "held out_msg");
      tick(1);
    end
    out_rdy = 1'b1;
    @(negedge clk);
    check_bit(in_rdy, 1'b1, "in_rdy after out_rdy rises");
    check_word(out_msg, data, "released out_msg");
    tick(1);
    in_val = 1'b0;
    finish_test("route 3 stream");

    set_route(2'd0);
    for (i = 0; i < 3; i++) begin
      data = $random(seed);
      inject(data);
    end
    read_burst(4);
    finish_test("spi loop");

    // fifth message waits in the decoder until a slot frees up
    for (i = 0; i < 5; i++) begin
      data = $random(seed);
      inject(data);
    end
    read_burst(6);
    finish_test("queue full");

    set_route(2'd3);
    output_spi = 1'b1;
    data = $random(seed);
    in_msg = data;
    in_val = 1'b1;
    @(negedge clk);
    check_bit(out_val, 1'b0, "out_val with output_spi");
    wait_in_accept();
    in_val = 1'b0;
    expected.push_back(data);
    read_burst(2);
    input_spi = 1'b1;
    in_msg = $random(seed);
    in_val = 1'b1;
    data = $random(seed);
    inject(data);
    @(negedge clk);
    check_bit(in_rdy, 1'b0, "in_rdy with input_spi");
    tick(1);
    read_burst(2);
    in_val = 1'b0;
    input_spi = 1'b0;
    output_spi = 1'b0;
    finish_test("force pins");

    set_route(2'd0);
    data = $random(seed);
    inject(data);
    // with these bits in front, a wrongly accepted short frame reads as op_route 3
    spi_xfer(make_frame(xbar_pkg::op_nop, 32'h0000_1000), xbar_pkg::frame_width, rsp);
    spi_xfer({20'h00003, 16'h0000}, 20, rsp);
    @(negedge clk);
    check_bit(in_rdy, 1'b0, "in_rdy after short frame");
    tick(1);
    read_burst(2);
    finish_test("short frame");

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             total_errors());
    if (total_errors() == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== project.f ====
src/xbar_pkg.sv
src/spi_minion.sv
src/spi_packet_decoder.sv
src/crossbar_blocking.sv
src/spi_response_queue.sv
src/spi_xbar_top.sv
tb/tb_spi_xbar.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the SPI crossbar testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_spi_xbar -f project.f

output=$(./obj_dir/Vtb_spi_xbar)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "SIMULATION PASSED"; then
  exit 0
else
  exit 1
fi
